// File: hdl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_DATA_W      8     // Register and bus width
`define CPU_NREGS       4     // R0..R3
`define CPU_IBUF_DEPTH  4     // Input bytes, also sender credits at reset
`define CPU_OPQ_DEPTH   2     // Decoded ops between decode and execute
`define CPU_OUT_CREDITS 2     // Output words in flight at reset

// Opcode field values, bits 7..4 of the first byte
`define CPU_OP_NOP      4'd0
`define CPU_OP_MOV      4'd1
`define CPU_OP_ADD      4'd2
`define CPU_OP_SUB      4'd3
`define CPU_OP_AND      4'd4
`define CPU_OP_OR       4'd5
`define CPU_OP_SHIFT    4'd6  // RLC/RRC/SETC/CLRC by subcode
`define CPU_OP_STACK    4'd7  // Only OUT survives here
`define CPU_OP_UNARY    4'd8  // NOT/NEG/INC/DEC by subcode
`define CPU_OP_LONG     4'd12 // Two-byte group, LDM when ra is 0

`endif

// File: hdl/cpu_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_W-1:0] data_t;
	typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

	// Operations that reach execute; NOPs and dropped opcodes never do
	typedef enum logic [4:0] {
		OP_MOV,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_RLC,
		OP_RRC,
		OP_SETC,
		OP_CLRC,
		OP_NOT,
		OP_NEG,
		OP_INC,
		OP_DEC,
		OP_OUT,
		OP_LDM
	} op_kind_e;

	typedef struct packed {
		op_kind_e kind;
		reg_idx_t ra;  // Destination of two-operand ops
		reg_idx_t rb;  // Source, or destination of unary/rotate/LDM
		data_t    imm; // Second byte of LDM
	} op_t;

	// Same bit order as the {V, C, N, Z} condition code register
	typedef struct packed {
		logic v;
		logic c;
		logic n;
		logic z;
	} flags_t;

	typedef struct packed {
		flags_t flags;
		data_t  data;
	} out_word_t;

endpackage

`default_nettype wire

// File: hdl/credit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     push,
	input  wire payload_t push_data,
	output logic          full,
	input  wire logic     pop,
	output payload_t      pop_data,
	output logic          empty
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t      mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;

	assign full     = (count == CW'(DEPTH));
	assign empty    = (count == '0);
	assign pop_data = mem[rd_ptr]; // Head is visible while not empty

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ; // Both or neither, level unchanged
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	// The producer's credits must keep it from ever writing into a full buffer
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst) push |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst) pop |-> !empty);

endmodule

`default_nettype wire

// File: hdl/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module instr_decode import cpu_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  instr_valid,
	input  wire logic [`CPU_DATA_W-1:0] instr_byte,
	output logic                       instr_credit,
	output logic                       op_push,
	output op_t                        op_data,
	input  wire logic                  op_full
);

	typedef enum logic {
		ST_FIRST,
		ST_SECOND
	} state_e;

	state_e                 state;
	logic [`CPU_DATA_W-1:0] ibuf_data;
	logic                   ibuf_empty;
	logic                   byte_pop;
	logic [`CPU_DATA_W-1:0] first_q; // First byte of a long instruction
	logic [3:0]             opc;
	reg_idx_t               fld_ra;
	reg_idx_t               fld_rb;
	op_kind_e               dec_kind;
	logic                   dec_valid;

	credit_fifo #(
		.payload_t (logic [`CPU_DATA_W-1:0]),
		.DEPTH     (`CPU_IBUF_DEPTH)
	) ibuf (
		.clk       (clk),
		.rst       (rst),
		.push      (instr_valid),
		.push_data (instr_byte),
		.full      (),
		.pop       (byte_pop),
		.pop_data  (ibuf_data),
		.empty     (ibuf_empty)
	);

	// Hold the byte in the buffer while the op queue has no room
	assign byte_pop     = !ibuf_empty && !op_full;
	assign instr_credit = byte_pop; // One credit back per byte consumed

	assign opc    = ibuf_data[7:4];
	assign fld_ra = ibuf_data[3:2];
	assign fld_rb = ibuf_data[1:0];

	always_comb begin
		dec_valid = 1'b0;
		dec_kind  = OP_MOV;
		case (opc)
			`CPU_OP_MOV: begin dec_valid = 1'b1; dec_kind = OP_MOV; end
			`CPU_OP_ADD: begin dec_valid = 1'b1; dec_kind = OP_ADD; end
			`CPU_OP_SUB: begin dec_valid = 1'b1; dec_kind = OP_SUB; end
			`CPU_OP_AND: begin dec_valid = 1'b1; dec_kind = OP_AND; end
			`CPU_OP_OR:  begin dec_valid = 1'b1; dec_kind = OP_OR;  end
			`CPU_OP_SHIFT: begin
				dec_valid = 1'b1;
				case (fld_ra)
					2'd0:    dec_kind = OP_RLC;
					2'd1:    dec_kind = OP_RRC;
					2'd2:    dec_kind = OP_SETC;
					default: dec_kind = OP_CLRC;
				endcase
			end
			`CPU_OP_STACK: begin
				dec_valid = (fld_ra == 2'd2); // PUSH, POP and IN are gone
				dec_kind  = OP_OUT;
			end
			`CPU_OP_UNARY: begin
				dec_valid = 1'b1;
				case (fld_ra)
					2'd0:    dec_kind = OP_NOT;
					2'd1:    dec_kind = OP_NEG;
					2'd2:    dec_kind = OP_INC;
					default: dec_kind = OP_DEC;
				endcase
			end
			`CPU_OP_NOP, `CPU_OP_LONG: ; // Nothing yet, or first half of a pair
			default: ; // Dropped single-byte opcodes
		endcase
	end

	always_comb begin
		op_data.kind = dec_kind;
		op_data.ra   = fld_ra;
		op_data.rb   = fld_rb;
		op_data.imm  = '0;
		op_push      = byte_pop && dec_valid;
		if (state == ST_SECOND) begin
			// Current byte is the immediate
			op_data.kind = OP_LDM;
			op_data.ra   = first_q[3:2];
			op_data.rb   = first_q[1:0];
			op_data.imm  = ibuf_data;
			op_push      = byte_pop && (first_q[3:2] == 2'd0); // LDD/STD just consume
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= ST_FIRST;
		end else if (byte_pop) begin
			if (state == ST_FIRST && opc == `CPU_OP_LONG)
				state <= ST_SECOND;
			else
				state <= ST_FIRST;
		end
	end

	always_ff @(posedge clk) begin
		if (byte_pop && state == ST_FIRST)
			first_q <= ibuf_data;
	end

	// Second-byte state only ever follows a stored opcode 12 byte
	a_long_pair: assert property (@(posedge clk) disable iff (!rst)
		(state == ST_SECOND) |-> (first_q[7:4] == `CPU_OP_LONG));

endmodule

`default_nettype wire

// File: hdl/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module alu_execute import cpu_pkg::*; (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic op_empty,
	input  wire op_t  op_data,
	output logic      op_pop,
	output logic      out_push,
	output out_word_t out_data,
	input  wire logic out_ready
);

	localparam int MSB = `CPU_DATA_W - 1;

	data_t                regs [`CPU_NREGS];
	flags_t               flags;
	flags_t               nxt_flags;
	data_t                a;
	data_t                b;
	data_t                res;
	logic [`CPU_DATA_W:0] sum;
	logic [`CPU_DATA_W:0] diff;
	logic                 wr_en;
	logic                 upd_zn;
	reg_idx_t             wr_idx;

	assign a    = regs[op_data.ra];
	assign b    = regs[op_data.rb];
	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b}; // Top bit is the borrow

	// OUT stalls here until the output side holds a credit
	assign op_pop   = !op_empty && ((op_data.kind != OP_OUT) || out_ready);
	assign out_push = op_pop && (op_data.kind == OP_OUT);

	assign out_data.flags = flags; // Flags as left by earlier ops
	assign out_data.data  = b;

	always_comb begin
		nxt_flags = flags;
		res       = b;
		wr_en     = 1'b0;
		upd_zn    = 1'b0;
		wr_idx    = op_data.rb;
		case (op_data.kind)
			OP_MOV: begin
				wr_en  = 1'b1;
				wr_idx = op_data.ra;
			end
			OP_ADD: begin
				res         = sum[MSB:0];
				wr_en       = 1'b1;
				wr_idx      = op_data.ra;
				upd_zn      = 1'b1;
				nxt_flags.c = sum[`CPU_DATA_W];
				nxt_flags.v = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
			end
			OP_SUB: begin
				res         = diff[MSB:0];
				wr_en       = 1'b1;
				wr_idx      = op_data.ra;
				upd_zn      = 1'b1;
				nxt_flags.c = diff[`CPU_DATA_W];
				nxt_flags.v = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
			end
			OP_AND, OP_OR: begin
				res    = (op_data.kind == OP_AND) ? (a & b) : (a | b);
				wr_en  = 1'b1;
				wr_idx = op_data.ra;
				upd_zn = 1'b1;
			end
			OP_RLC: begin
				res         = {b[MSB-1:0], flags.c}; // Carry enters at bit 0
				wr_en       = 1'b1;
				upd_zn      = 1'b1;
				nxt_flags.c = b[MSB];
			end
			OP_RRC: begin
				res         = {flags.c, b[MSB:1]};
				wr_en       = 1'b1;
				upd_zn      = 1'b1;
				nxt_flags.c = b[0];
			end
			OP_SETC: nxt_flags.c = 1'b1;
			OP_CLRC: nxt_flags.c = 1'b0;
			OP_NOT, OP_NEG, OP_INC, OP_DEC: begin
				case (op_data.kind)
					OP_NOT:  res = ~b;
					OP_NEG:  res = data_t'(0) - b;
					OP_INC:  res = b + data_t'(1);
					default: res = b - data_t'(1);
				endcase
				wr_en  = 1'b1;
				upd_zn = 1'b1;
			end
			OP_LDM: begin
				res   = op_data.imm;
				wr_en = 1'b1;
			end
			default: ; // OUT reads only
		endcase
		if (upd_zn) begin
			nxt_flags.z = (res == '0);
			nxt_flags.n = res[MSB];
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < `CPU_NREGS; i++)
				regs[i] <= '0;
			flags <= '0;
		end else if (op_pop) begin
			if (wr_en)
				regs[wr_idx] <= res;
			flags <= nxt_flags;
		end
	end

	// Queue head always holds a legal operation
	a_legal_kind: assert property (@(posedge clk) disable iff (!rst)
		!op_empty |-> (op_data.kind <= OP_LDM));

endmodule

`default_nettype wire

// File: hdl/out_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module out_result import cpu_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst,
	input  wire logic      out_push,
	input  wire out_word_t out_data,
	output logic           out_ready,
	output logic           out_valid,
	output out_word_t      out_word,
	input  wire logic      out_credit
);

	localparam int CW = $clog2(`CPU_OUT_CREDITS + 1);

	logic [CW-1:0] credits; // Words the consumer can still accept

	assign out_ready = (credits != '0);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			credits   <= CW'(`CPU_OUT_CREDITS);
			out_valid <= 1'b0;
		end else begin
			out_valid <= out_push; // Single-cycle strobe
			case ({out_push, out_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: ; // Spend and return cancel out
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (out_push)
			out_word <= out_data;
	end

	// Consumer returning more credits than it was ever given
	a_credit_max: assert property (@(posedge clk) disable iff (!rst)
		credits <= CW'(`CPU_OUT_CREDITS));
	a_push_credit: assert property (@(posedge clk) disable iff (!rst)
		out_push |-> out_ready);

endmodule

`default_nettype wire

// File: hdl/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_core import cpu_pkg::*; (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   instr_valid,
	input  wire logic [`CPU_DATA_W-1:0] instr_byte,
	output logic                        instr_credit,
	output logic                        out_valid,
	output out_word_t                   out_word,
	input  wire logic                   out_credit
);

	logic      op_push;
	logic      op_full;
	op_t       op_in;
	logic      op_pop;
	logic      op_empty;
	op_t       op_head;
	logic      res_push;
	out_word_t res_data;
	logic      res_ready;

	instr_decode u_decode (
		.clk          (clk),
		.rst          (rst),
		.instr_valid  (instr_valid),
		.instr_byte   (instr_byte),
		.instr_credit (instr_credit),
		.op_push      (op_push),
		.op_data      (op_in),
		.op_full      (op_full)
	);

	// Decoded op queue between decode and execute
	credit_fifo #(
		.payload_t (op_t),
		.DEPTH     (`CPU_OPQ_DEPTH)
	) u_opq (
		.clk       (clk),
		.rst       (rst),
		.push      (op_push),
		.push_data (op_in),
		.full      (op_full),
		.pop       (op_pop),
		.pop_data  (op_head),
		.empty     (op_empty)
	);

	alu_execute u_exec (
		.clk       (clk),
		.rst       (rst),
		.op_empty  (op_empty),
		.op_data   (op_head),
		.op_pop    (op_pop),
		.out_push  (res_push),
		.out_data  (res_data),
		.out_ready (res_ready)
	);

	out_result u_out (
		.clk        (clk),
		.rst        (rst),
		.out_push   (res_push),
		.out_data   (res_data),
		.out_ready  (res_ready),
		.out_valid  (out_valid),
		.out_word   (out_word),
		.out_credit (out_credit)
	);

endmodule

`default_nettype wire

// File: tests/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_checker import cpu_pkg::*; (
	input wire logic                   clk,
	input wire logic                   rst,
	input wire logic                   instr_valid,
	input wire logic [`CPU_DATA_W-1:0] instr_byte,
	input wire logic                   instr_credit,
	input wire logic                   out_valid,
	input wire out_word_t              out_word,
	input wire logic                   out_credit
);

	logic [7:0]  r [`CPU_NREGS]; // Model register file
	logic        v;
	logic        c;
	logic        n;
	logic        z;
	logic        second;         // Next byte completes an opcode 12 pair
	logic [7:0]  long_first;
	logic        started;
	logic [11:0] exp_q [$];      // {V, C, N, Z, data} per pending OUT
	int          exp_count;
	int          in_credits;
	int          out_outstanding;
	int          error_count;
	int          word_count;

	initial begin
		for (int i = 0; i < `CPU_NREGS; i++)
			r[i] = 8'h00;
		{v, c, n, z} = 4'b0000;
		second          = 1'b0;
		long_first      = 8'h00;
		started         = 1'b0;
		exp_count       = 0;
		in_credits      = `CPU_IBUF_DEPTH;
		out_outstanding = 0;
		error_count     = 0;
		word_count      = 0;
	end

	// Instruction set model, one accepted byte at a time
	task automatic model_byte(input logic [7:0] b);
		logic [1:0] ra;
		logic [1:0] rb;
		logic [7:0] x;
		logic [7:0] y;
		logic [7:0] res;
		logic [8:0] wide;
		logic       zn;
		int         sx;
		ra = b[3:2];
		rb = b[1:0];
		x  = r[ra];
		y  = r[rb];
		zn = 1'b0;
		res = 8'h00;
		if (second) begin
			second = 1'b0;
			if (long_first[3:2] == 2'd0)
				r[long_first[1:0]] = b; // LDM immediate
		end else begin
			case (b[7:4])
				`CPU_OP_MOV: r[ra] = y;
				`CPU_OP_ADD: begin
					wide  = {1'b0, x} + {1'b0, y};
					sx    = $signed(x) + $signed(y);
					res   = wide[7:0];
					c     = wide[8];
					v     = (sx > 127) || (sx < -128);
					r[ra] = res;
					zn    = 1'b1;
				end
				`CPU_OP_SUB: begin
					sx    = $signed(x) - $signed(y);
					res   = x - y;
					c     = (x < y); // Borrow
					v     = (sx > 127) || (sx < -128);
					r[ra] = res;
					zn    = 1'b1;
				end
				`CPU_OP_AND, `CPU_OP_OR: begin
					res   = (b[7:4] == `CPU_OP_AND) ? (x & y) : (x | y);
					r[ra] = res;
					zn    = 1'b1;
				end
				`CPU_OP_SHIFT: begin
					case (ra)
						2'd0: begin
							res = {y[6:0], c};
							c   = y[7];
						end
						2'd1: begin
							res = {c, y[7:1]};
							c   = y[0];
						end
						2'd2: c = 1'b1;
						default: c = 1'b0;
					endcase
					if (ra < 2'd2) begin
						r[rb] = res;
						zn    = 1'b1;
					end
				end
				`CPU_OP_STACK: begin
					if (ra == 2'd2)
						exp_q.push_back({v, c, n, z, y}); // OUT
				end
				`CPU_OP_UNARY: begin
					case (ra)
						2'd0: res = ~y;
						2'd1: res = -y;
						2'd2: res = y + 8'd1;
						default: res = y - 8'd1;
					endcase
					r[rb] = res;
					zn    = 1'b1;
				end
				`CPU_OP_LONG: begin
					second     = 1'b1;
					long_first = b;
				end
				default: ; // NOP and dropped opcodes
			endcase
			if (zn) begin
				z = (res == 8'h00);
				n = res[7];
			end
		end
		exp_count = exp_q.size();
	endtask

	task automatic track_credits();
		int nxt;
		if (instr_valid && in_credits == 0) begin
			$display("Instruction byte sent at %0t with no input credit left", $time);
			error_count++;
		end
		nxt = in_credits - (instr_valid ? 1 : 0) + (instr_credit ? 1 : 0);
		if (nxt > `CPU_IBUF_DEPTH) begin
			$display("Input credits returned at %0t exceed the buffer depth", $time);
			error_count++;
		end
		in_credits = nxt;
		nxt = out_outstanding + (out_valid ? 1 : 0) - (out_credit ? 1 : 0);
		if (nxt > `CPU_OUT_CREDITS) begin
			$display("Output word at %0t sent beyond the granted credits", $time);
			error_count++;
		end
		out_outstanding = nxt;
	endtask

	task automatic compare_word();
		logic [11:0] want;
		if (exp_q.size() == 0) begin
			$display("Output word %h at %0t with no OUT instruction pending", out_word, $time);
			error_count++;
		end else begin
			want      = exp_q.pop_front();
			exp_count = exp_q.size();
			word_count++;
			if (out_word.flags != want[11:8] || out_word.data != want[7:0]) begin
				$display("ERROR at %0t: out_word data %h VCNZ %b, expected data %h VCNZ %b",
					$time, out_word.data, out_word.flags, want[7:0], want[11:8]);
				error_count++;
			end
		end
	endtask

	// Called by the testbench once traffic has stopped
	task automatic check_drained();
		if (exp_q.size() != 0) begin
			$display("%0d expected output words never appeared", exp_q.size());
			error_count++;
		end
		if (in_credits != `CPU_IBUF_DEPTH) begin
			$display("Only %0d of %0d input credits came back", in_credits, `CPU_IBUF_DEPTH);
			error_count++;
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			if (!started && (instr_credit || out_valid)) begin
				$display("DUT output active at %0t before any instruction byte", $time);
				error_count++;
			end
			track_credits();
			if (out_valid)
				compare_word();
			if (instr_valid) begin
				started = 1'b1;
				model_byte(instr_byte);
			end
		end
	end

endmodule

`default_nettype wire

// File: tests/tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_cpu_core import cpu_pkg::*; ();

	localparam int CLK_PERIOD     = 100;
	localparam int NUM_INSTR      = 2000;
	localparam int TIMEOUT_CYCLES = NUM_INSTR * 30;

	logic                   clk;
	logic                   rst;
	logic                   instr_valid;
	logic [`CPU_DATA_W-1:0] instr_byte;
	logic                   instr_credit;
	logic                   out_valid;
	out_word_t              out_word;
	logic                   out_credit;

	integer     seed;
	integer     out_seed;
	int         in_credits; // Sender's own count
	int         owed;       // Words taken, credit not yet returned
	int         quiet;      // Cycles left without credit returns
	int         pick;
	int         k;
	logic [7:0] b0;
	logic [7:0] b1;
	logic       long_instr;

	cpu_core uut (
		.clk          (clk),
		.rst          (rst),
		.instr_valid  (instr_valid),
		.instr_byte   (instr_byte),
		.instr_credit (instr_credit),
		.out_valid    (out_valid),
		.out_word     (out_word),
		.out_credit   (out_credit)
	);

	cpu_checker u_chk (
		.clk          (clk),
		.rst          (rst),
		.instr_valid  (instr_valid),
		.instr_byte   (instr_byte),
		.instr_credit (instr_credit),
		.out_valid    (out_valid),
		.out_word     (out_word),
		.out_credit   (out_credit)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			in_credits <= `CPU_IBUF_DEPTH;
			owed       <= 0;
		end else begin
			in_credits <= in_credits - (instr_valid ? 1 : 0) + (instr_credit ? 1 : 0);
			owed       <= owed + (out_valid ? 1 : 0) - (out_credit ? 1 : 0);
		end
	end

	// Consumer side, with random stalls
	always @(negedge clk) begin
		if (quiet > 0) begin
			quiet      = quiet - 1;
			out_credit = 1'b0;
		end else if ($unsigned($random(out_seed)) % 50 == 0) begin
			quiet      = 10 + $unsigned($random(out_seed)) % 40;
			out_credit = 1'b0;
		end else begin
			out_credit = (owed > 0) && ($unsigned($random(out_seed)) % 3 != 0);
		end
	end

	task automatic send_byte(input logic [7:0] b);
		@(negedge clk);
		while (in_credits == 0) begin
			instr_valid = 1'b0;
			@(negedge clk);
		end
		instr_valid = 1'b1;
		instr_byte  = b;
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		instr_valid = 1'b0;
	endtask

	initial begin
		clk         = 1'b0;
		rst         = 1'b0;
		instr_valid = 1'b0;
		instr_byte  = '0;
		out_credit  = 1'b0;
		quiet       = 0;
		seed        = 32'h192a_9b71;
		out_seed    = seed ^ 32'h3c3c_0f0f;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		repeat (5) idle_cycle(); // Outputs must stay quiet here
		for (int i = 0; i < NUM_INSTR; i++) begin
			pick       = $unsigned($random(seed)) % 100;
			b0         = $random(seed);
			b1         = $random(seed);
			k          = $unsigned($random(seed)) % 7;
			long_instr = 1'b0;
			if (pick < 20) begin
				b0[7:2] = {`CPU_OP_STACK, 2'd2}; // OUT
			end else if (pick < 62) begin
				b0[7:4] = (k == 6) ? `CPU_OP_UNARY : 4'(k + 1);
			end else if (pick < 74) begin
				b0[7:2]    = {`CPU_OP_LONG, 2'd0}; // LDM
				long_instr = 1'b1;
			end else if (pick < 80) begin
				b0[7:4]    = `CPU_OP_LONG;
				long_instr = 1'b1;
				if (b0[3:2] == 2'd0)
					b0[3:2] = 2'd1;
			end else if (pick < 86) begin
				b0[7:4] = `CPU_OP_STACK;
				if (b0[3:2] == 2'd2)
					b0[3:2] = 2'd3;
			end else if (pick < 92) begin
				b0[7:4] = `CPU_OP_NOP;
			end else begin
				k       = k % 6;
				b0[7:4] = (k < 3) ? 4'(9 + k) : 4'(10 + k); // 9..11, 13..15
			end
			if ($unsigned($random(seed)) % 8 == 0)
				idle_cycle();
			send_byte(b0);
			if (long_instr)
				send_byte(b1);
		end
		idle_cycle();
		while (in_credits != `CPU_IBUF_DEPTH || owed != 0 || u_chk.exp_count != 0)
			@(negedge clk);
		repeat (10) @(negedge clk);
		u_chk.check_drained();
		$display("Output words checked: %0d, errors: %0d", u_chk.word_count, u_chk.error_count);
		if (u_chk.error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: traffic did not drain within %0d cycles", TIMEOUT_CYCLES);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/credit_fifo.sv
hdl/instr_decode.sv
hdl/alu_execute.sv
hdl/out_result.sv
hdl/cpu_core.sv
tests/cpu_checker.sv
tests/tb_cpu_core.sv

// File: Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - hdl

sources:
  - hdl/cpu_pkg.sv
  - hdl/credit_fifo.sv
  - hdl/instr_decode.sv
  - hdl/alu_execute.sv
  - hdl/out_result.sv
  - hdl/cpu_core.sv
  - target: test
    files:
      - tests/cpu_checker.sv
      - tests/tb_cpu_core.sv
